// File: Makefile
# Verilator build and run of the EEPROM controller testbench

VERILATOR ?= verilator
TOP       ?= eeprom_tb
FILELIST  ?= eeprom_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG FAIL_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/eeprom_checker.sv
`timescale 1ns/1ps
module eeprom_checker import eeprom_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         busy,
  input  logic         ack,
  input  logic         nack,
  input  byte_t        rdata,
  input  logic         scl,
  input  logic         sda_low,
  input  logic         sda,
  input  logic         exp_valid,
  input  logic         exp_read,
  input  eeprom_addr_t exp_addr,
  input  byte_t        exp_data,
  input  logic         exp_nack,
  output int           errors,
  output int           pending
);

  logic [20:0] exp_q [$];  // {read, nack, addr, data}
  logic [20:0] entry;
  logic        started;

  initial begin
    errors = 0;
    pending = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
    end else begin
      if (!started && !exp_valid && (!scl || sda_low || busy || ack)) begin
        $display("FAIL %0t: not idle after reset, scl=%b sda_low=%b busy=%b ack=%b",
                 $time, scl, sda_low, busy, ack);
        errors++;
      end
      if (exp_valid) begin
        started <= 1'b1;
        exp_q.push_back({exp_read, exp_nack, exp_addr, exp_data});
      end
      if (ack && exp_q.size() == 0) begin
        $display("FAIL %0t: ack with no request outstanding", $time);
        errors++;
      end else if (ack) begin
        entry = exp_q.pop_front();
        if (nack !== entry[19]) begin
          $display("FAIL %0t: nack %b expected %b at addr %03h",
                   $time, nack, entry[19], entry[18:8]);
          errors++;
        end
        if (entry[20] && !entry[19] && rdata !== entry[7:0]) begin
          $display("FAIL %0t: rdata %02h expected %02h at addr %03h",
                   $time, rdata, entry[7:0], entry[18:8]);
          errors++;
        end
        if (!scl || !sda) begin
          $display("FAIL %0t: bus not released by a stop at ack", $time);
          errors++;
        end
      end
      pending = exp_q.size();
    end
  end

endmodule

// File: dv/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model import eeprom_pkg::*; (
  input  logic scl,
  input  logic sda,     // resolved line
  input  logic ack_en,
  output logic sda_pull // 1 pulls the line low
);

  typedef enum {st_idle, st_ctrl, st_addr, st_wdata, st_rdata} slave_state_t;

  byte_t        mem [0:2047];
  slave_state_t state = st_idle;
  int           bit_cnt = 0;  // 8 ack slot of a received byte, 10 master ack slot
  byte_t        shreg = '0;
  eeprom_addr_t ptr = '0;
  logic         scl_q = 1'b1;
  logic         sda_q = 1'b1;

  initial begin
    sda_pull <= 1'b0;
    for (int i = 0; i < 2048; i++) begin
      mem[i] = 8'hFF;  // erased
    end
  end

  task automatic take_byte();
    if (!ack_en || (state == st_ctrl && shreg[7:4] != DEVICE_CODE)) begin
      state = st_idle;  // no acknowledge
    end else begin
      sda_pull <= 1'b1;
      case (state)
        st_ctrl: begin
          ptr[10:8] = shreg[3:1];
          state = shreg[0] ? st_rdata : st_addr;
        end
        st_addr: begin
          ptr[7:0] = shreg;
          state = st_wdata;
        end
        default: begin
          mem[ptr] = shreg;
          state = st_idle;
        end
      endcase
    end
  endtask

  always @(scl or sda) begin
    if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
      state = st_ctrl;  // start or repeated start
      bit_cnt = 0;
      sda_pull <= 1'b0;
    end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
      state = st_idle;  // stop
      sda_pull <= 1'b0;
    end else if (scl === 1'b1 && scl_q === 1'b0) begin
      if (state inside {st_ctrl, st_addr, st_wdata} && bit_cnt < 8) begin
        shreg = {shreg[6:0], sda};
        bit_cnt++;
      end else if (state == st_rdata && bit_cnt < 8) begin
        bit_cnt++;
      end else if (state == st_rdata && bit_cnt == 10) begin
        state = st_idle;  // single byte only
      end
    end else if (scl === 1'b0 && scl_q === 1'b1) begin
      if (bit_cnt == 8 && state inside {st_ctrl, st_addr, st_wdata}) begin
        take_byte();
        bit_cnt = 9;
      end else if (bit_cnt == 9) begin
        bit_cnt = 0;
        if (state == st_rdata) begin
          shreg = mem[ptr];
          sda_pull <= !shreg[7];
        end else begin
          sda_pull <= 1'b0;
        end
      end else if (state == st_rdata && bit_cnt < 8) begin
        sda_pull <= !shreg[7 - bit_cnt];
      end else if (state == st_rdata && bit_cnt == 8) begin
        sda_pull <= 1'b0;  // master ack slot
        bit_cnt = 10;
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

// File: dv/eeprom_properties.sv
`timescale 1ns/1ps
module eeprom_properties (
  input logic clk,
  input logic reset,
  input logic scl,
  input logic sda_low,
  input logic busy,
  input logic ack
);

  // sda moves a quarter away from any scl edge
  sda_stable_a: assert property (@(posedge clk) disable iff (reset)
    $changed(sda_low) |-> $stable(scl))
    else $error("sda changed on the same clock edge as scl");

  stop_edge_a: assert property (@(posedge clk) disable iff (reset)
    $fell(sda_low) && scl |=> ack)
    else $error("sda rose with scl high but no ack followed");

  ack_pulse_a: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack longer than one cycle");

  busy_fall_a: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> $past(ack))
    else $error("busy fell without a preceding ack");

  idle_scl_a: assert property (@(posedge clk) disable iff (reset) !busy |-> scl)
    else $error("scl low while not busy");

endmodule

// File: dv/eeprom_tb.sv
`timescale 1ns/1ps
module eeprom_tb import eeprom_pkg::*; ();

  logic         clk;
  logic         reset;
  logic         wr;
  logic         rd;
  eeprom_addr_t addr;
  byte_t        wdata;
  logic         busy;
  logic         ack;
  logic         nack;
  byte_t        rdata;
  logic         scl;
  logic         sda_low;
  logic         model_pull;
  logic         sda;
  logic         ack_en;
  logic         exp_valid;
  logic         exp_read;
  eeprom_addr_t exp_addr;
  byte_t        exp_data;
  logic         exp_nack;
  int           errors;
  int           pending;
  int           timeouts;
  logic [31:0]  rng;
  byte_t        shadow [0:2047];
  eeprom_addr_t written [$];

  assign sda = !(sda_low || model_pull);  // wired-AND with pull-up

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  eeprom_top #(.CLK_DIV(4)) dut_i (
    .clk(clk), .reset(reset), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
    .busy(busy), .ack(ack), .nack(nack), .rdata(rdata),
    .scl(scl), .sda_low(sda_low), .sda_in(sda)
  );

  eeprom_model model_i (.scl(scl), .sda(sda), .ack_en(ack_en), .sda_pull(model_pull));

  eeprom_checker checker_i (
    .clk(clk), .reset(reset), .busy(busy), .ack(ack), .nack(nack), .rdata(rdata),
    .scl(scl), .sda_low(sda_low), .sda(sda), .exp_valid(exp_valid),
    .exp_read(exp_read), .exp_addr(exp_addr), .exp_data(exp_data),
    .exp_nack(exp_nack), .errors(errors), .pending(pending)
  );

  bind eeprom_top eeprom_properties props_i (
    .clk(clk), .reset(reset), .scl(scl), .sda_low(sda_low), .busy(busy), .ack(ack)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected read byte, FF where never written
  function automatic byte_t expected_read(input eeprom_addr_t a);
    return shadow[a];
  endfunction

  task automatic pulse_request(input logic is_wr, input eeprom_addr_t a, input byte_t d);
    @(posedge clk);
    wr    <= is_wr;
    rd    <= !is_wr;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
  endtask

  task automatic send(input logic is_wr, input eeprom_addr_t a, input byte_t d,
                      input logic no_ack);
    fork
      pulse_request(is_wr, a, d);
      begin
        @(posedge clk);
        exp_valid <= 1'b1;  // lands on the same edge as the request
        exp_read  <= !is_wr;
        exp_addr  <= a;
        exp_data  <= expected_read(a);
        exp_nack  <= no_ack;
        @(posedge clk);
        exp_valid <= 1'b0;
      end
    join
    if (is_wr && !no_ack) begin
      shadow[a] = d;
      written.push_back(a);
    end
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!ack && n < 2000);
    if (!ack) begin
      $display("timeout at %0t: no ack within 2000 cycles", $time);
      timeouts++;
    end
  endtask

  task automatic transact(input logic is_wr, input eeprom_addr_t a, input byte_t d,
                          input logic no_ack);
    send(is_wr, a, d, no_ack);
    wait_ack();
  endtask

  initial begin
    int idx;
    reset     <= 1'b1;
    wr        <= 1'b0;
    rd        <= 1'b0;
    addr      <= '0;
    wdata     <= '0;
    ack_en    <= 1'b1;
    exp_valid <= 1'b0;
    exp_read  <= 1'b0;
    exp_addr  <= '0;
    exp_data  <= '0;
    exp_nack  <= 1'b0;
    timeouts = 0;
    rng = 32'd6;
    for (int i = 0; i < 2048; i++) begin
      shadow[i] = 8'hFF;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (40) @(posedge clk);  // idle bus window

    // write then read back, some with high address bits
    transact(1'b1, 11'h000, 8'h3C, 1'b0);
    transact(1'b0, 11'h000, 8'h00, 1'b0);
    transact(1'b1, 11'h5A7, 8'hC5, 1'b0);
    transact(1'b0, 11'h5A7, 8'h00, 1'b0);
    transact(1'b1, 11'h7FF, 8'h81, 1'b0);
    transact(1'b0, 11'h7FF, 8'h00, 1'b0);
    transact(1'b0, 11'h0A7, 8'h00, 1'b0);  // same low byte, other block
    transact(1'b0, 11'h0FF, 8'h00, 1'b0);

    for (int i = 0; i < 60; i++) begin
      rng = xorshift32(rng);
      if (rng[0]) begin
        transact(1'b1, rng[18:8], rng[31:24], 1'b0);
      end else if (rng[1] && written.size() > 0) begin
        idx = int'(rng[15:4]) % written.size();
        transact(1'b0, written[idx], 8'h00, 1'b0);
      end else begin
        transact(1'b0, rng[18:8], 8'h00, 1'b0);  // mostly never written
      end
    end

    // slave gives no acknowledge
    ack_en <= 1'b0;
    transact(1'b1, 11'h5A7, 8'h18, 1'b1);
    transact(1'b0, 11'h5A7, 8'h00, 1'b1);
    ack_en <= 1'b1;
    transact(1'b0, 11'h5A7, 8'h00, 1'b0);

    // requests while busy are dropped
    send(1'b1, 11'h1E4, 8'h77, 1'b0);
    pulse_request(1'b1, 11'h2D9, 8'h12);
    pulse_request(1'b0, 11'h2D9, 8'h00);
    wait_ack();
    repeat (800) @(posedge clk);  // window for a stray ack
    transact(1'b0, 11'h2D9, 8'h00, 1'b0);
    transact(1'b0, 11'h1E4, 8'h00, 1'b0);

    repeat (10) @(posedge clk);
    $display("errors %0d  timeouts %0d  unanswered %0d", errors, timeouts, pending);
    if (errors == 0 && timeouts == 0 && pending == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: eeprom_ctrl.f
source/eeprom_pkg.sv
source/scl_phase_gen.sv
source/byte_sequencer.sv
source/eeprom_wr.sv
source/eeprom_top.sv
dv/eeprom_model.sv
dv/eeprom_checker.sv
dv/eeprom_properties.sv
dv/eeprom_tb.sv

// File: source/byte_sequencer.sv
`timescale 1ns/1ps
module byte_sequencer import eeprom_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  bus_op_t op,
  input  logic    op_valid,
  input  byte_t   tx_byte,
  input  logic    master_nack,
  input  logic    change_tick,
  input  logic    sample_tick,
  input  logic    sda_in,
  output logic    run,
  output logic    sda_low,
  output byte_t   rx_byte,
  output logic    slave_ack,
  output logic    op_done
);

  logic       active;
  bus_op_t    cur_op;
  logic [3:0] bit_cnt;  // 0..7 data bits, 8 is the ack slot
  logic       last_bit;
  logic       accept;
  byte_t      shift_out;
  byte_t      shift_in;
  logic       mnack;    // latched master_nack of the current read

  assign last_bit = (bit_cnt == 4'd8);
  assign accept   = op_valid && !active;
  assign rx_byte  = shift_in;

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      cur_op    <= op_start;
      bit_cnt   <= '0;
      run       <= 1'b0;
      sda_low   <= 1'b0;
      slave_ack <= 1'b0;
      op_done   <= 1'b0;
    end else begin
      op_done <= 1'b0;
      if (accept) begin
        active  <= 1'b1;
        cur_op  <= op;
        bit_cnt <= '0;
        run     <= 1'b1;  // stays up until the stop is done
      end else if (active) begin
        case (cur_op)
          op_start: begin
            if (change_tick) begin
              sda_low <= 1'b0;
            end
            if (sample_tick) begin
              sda_low <= 1'b1;  // sda falls with scl high
              active  <= 1'b0;
              op_done <= 1'b1;
            end
          end
          op_write: begin
            if (change_tick) begin
              sda_low <= last_bit ? 1'b0 : !shift_out[7];  // let go for the ack
            end
            if (sample_tick) begin
              if (last_bit) begin
                slave_ack <= !sda_in;
                active    <= 1'b0;
                op_done   <= 1'b1;
              end else begin
                bit_cnt <= bit_cnt + 4'd1;
              end
            end
          end
          op_read: begin
            // released for data, master ack on the ninth bit
            if (change_tick) begin
              sda_low <= last_bit && !mnack;
            end
            if (sample_tick) begin
              if (last_bit) begin
                active  <= 1'b0;
                op_done <= 1'b1;
              end else begin
                bit_cnt <= bit_cnt + 4'd1;
              end
            end
          end
          op_stop: begin
            if (change_tick) begin
              sda_low <= 1'b1;
            end
            if (sample_tick) begin
              sda_low <= 1'b0;  // sda rises with scl high
              run     <= 1'b0;
              active  <= 1'b0;
              op_done <= 1'b1;
            end
          end
          default: begin
            active <= 1'b0;
          end
        endcase
      end
    end
  end

  // data path of the shift sub-machines
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_out <= tx_byte;
      mnack     <= master_nack;
    end else if (active && change_tick && cur_op == op_write && !last_bit) begin
      shift_out <= {shift_out[6:0], 1'b0};  // msb first
    end
    if (active && sample_tick && cur_op == op_read && !last_bit) begin
      shift_in <= {shift_in[6:0], sda_in};
    end
  end

endmodule

// File: source/eeprom_pkg.sv
package eeprom_pkg;

  // 11 bits cover the 2K byte array of a 24C16
  typedef logic [10:0] eeprom_addr_t;

  typedef logic [7:0] byte_t;

  // upper nibble of every control byte
  localparam logic [3:0] DEVICE_CODE = 4'b1010;

  // commands to the byte sequencer
  typedef enum logic [1:0] {
    op_start,  // start or repeated start
    op_write,  // 8 bits out, slave ack in
    op_read,   // 8 bits in, master ack out
    op_stop
  } bus_op_t;

  typedef enum logic [3:0] {
    idle,
    write_start,
    ctrl_write,
    addr_write,
    data_write,
    read_start,   // repeated start
    ctrl_read,
    data_read,
    stop,
    ackn
  } main_state_t;

endpackage

// File: source/eeprom_top.sv
`timescale 1ns/1ps
module eeprom_top import eeprom_pkg::*; #(
  parameter int CLK_DIV = 4  // clk cycles per scl quarter
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         wr,
  input  logic         rd,
  input  eeprom_addr_t addr,
  input  byte_t        wdata,
  output logic         busy,
  output logic         ack,
  output logic         nack,
  output byte_t        rdata,
  output logic         scl,
  output logic         sda_low,
  input  logic         sda_in
);

  bus_op_t op;
  logic    op_valid;
  byte_t   tx_byte;
  logic    master_nack;
  logic    op_done;
  byte_t   rx_byte;
  logic    slave_ack;
  logic    run;
  logic    change_tick;
  logic    sample_tick;

  eeprom_wr u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .wr          (wr),
    .rd          (rd),
    .addr        (addr),
    .wdata       (wdata),
    .busy        (busy),
    .ack         (ack),
    .nack        (nack),
    .rdata       (rdata),
    .op          (op),
    .op_valid    (op_valid),
    .tx_byte     (tx_byte),
    .master_nack (master_nack),
    .op_done     (op_done),
    .rx_byte     (rx_byte),
    .slave_ack   (slave_ack)
  );

  byte_sequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .op          (op),
    .op_valid    (op_valid),
    .tx_byte     (tx_byte),
    .master_nack (master_nack),
    .change_tick (change_tick),
    .sample_tick (sample_tick),
    .sda_in      (sda_in),
    .run         (run),
    .sda_low     (sda_low),
    .rx_byte     (rx_byte),
    .slave_ack   (slave_ack),
    .op_done     (op_done)
  );

  scl_phase_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_scl (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .scl         (scl),
    .change_tick (change_tick),
    .sample_tick (sample_tick)
  );

endmodule

// File: source/eeprom_wr.sv
`timescale 1ns/1ps
module eeprom_wr import eeprom_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         wr,
  input  logic         rd,
  input  eeprom_addr_t addr,
  input  byte_t        wdata,
  output logic         busy,
  output logic         ack,
  output logic         nack,
  output byte_t        rdata,
  output bus_op_t      op,
  output logic         op_valid,
  output byte_t        tx_byte,
  output logic         master_nack,
  input  logic         op_done,
  input  byte_t        rx_byte,
  input  logic         slave_ack
);

  main_state_t  state;
  main_state_t  state_nxt;
  logic         accept;
  logic         read_q;   // current request is a read
  logic         nack_q;
  eeprom_addr_t addr_q;
  byte_t        wdata_q;
  byte_t        rdata_q;

  function automatic byte_t ctrl_byte(input eeprom_addr_t a, input logic rnw);
    return {DEVICE_CODE, a[10:8], rnw};
  endfunction

  assign accept      = (state == idle) && (wr || rd);
  assign busy        = (state != idle);
  assign ack         = (state == ackn);
  assign nack        = nack_q;
  assign rdata       = rdata_q;
  assign master_nack = 1'b1;  // single byte read, no ack from master

  // operation and byte follow the state, latched by the sequencer on op_valid
  always_comb begin
    op      = op_stop;
    tx_byte = '0;
    case (state)
      write_start, read_start: op = op_start;
      ctrl_write: begin
        op      = op_write;
        tx_byte = ctrl_byte(addr_q, 1'b0);
      end
      addr_write: begin
        op      = op_write;
        tx_byte = addr_q[7:0];
      end
      data_write: begin
        op      = op_write;
        tx_byte = wdata_q;
      end
      ctrl_read: begin
        op      = op_write;
        tx_byte = ctrl_byte(addr_q, 1'b1);
      end
      data_read: op = op_read;
      default:   op = op_stop;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:        if (wr || rd) state_nxt = write_start;
      write_start: if (op_done) state_nxt = ctrl_write;
      ctrl_write:  if (op_done) state_nxt = slave_ack ? addr_write : stop;
      addr_write: begin
        if (op_done) begin
          if (!slave_ack) state_nxt = stop;  // skip the rest, still close the frame
          else if (read_q) state_nxt = read_start;
          else state_nxt = data_write;
        end
      end
      data_write:  if (op_done) state_nxt = stop;
      read_start:  if (op_done) state_nxt = ctrl_read;
      ctrl_read:   if (op_done) state_nxt = slave_ack ? data_read : stop;
      data_read:   if (op_done) state_nxt = stop;
      stop:        if (op_done) state_nxt = ackn;
      ackn:        state_nxt = idle;
      default:     state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      op_valid <= 1'b0;
      read_q   <= 1'b0;
      nack_q   <= 1'b0;
    end else begin
      state <= state_nxt;
      // one strobe per bus operation
      op_valid <= (state_nxt != state) && (state_nxt != ackn) && (state_nxt != idle);
      if (accept) begin
        read_q <= !wr;  // wr wins
        nack_q <= 1'b0;
      end else if (op_done && op == op_write && !slave_ack) begin
        nack_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (state == data_read && op_done) begin
      rdata_q <= rx_byte;
    end
  end

endmodule

// File: source/scl_phase_gen.sv
`timescale 1ns/1ps
module scl_phase_gen #(
  parameter int CLK_DIV = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic run,
  output logic scl,
  output logic change_tick,
  output logic sample_tick
);

  localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [CNT_W-1:0] Q_LAST = CNT_W'(CLK_DIV - 1);

  logic [CNT_W-1:0] q_cnt;  // clk cycles within a quarter
  logic [1:0]       phase;  // 0,1 scl low and 2,3 scl high
  logic             q_end;

  assign q_end = (q_cnt == Q_LAST);

  // parked in the last high quarter while the bus is idle
  always_ff @(posedge clk) begin
    if (reset || !run) begin
      q_cnt <= '0;
      phase <= 2'd3;
    end else if (q_end) begin
      q_cnt <= '0;
      phase <= phase + 2'd1;
    end else begin
      q_cnt <= q_cnt + 1'b1;
    end
  end

  assign scl = phase[1];

  // mid low, sda may move after this edge
  assign change_tick = run && q_end && (phase == 2'd0);
  // mid high, sample point and start/stop edges
  assign sample_tick = run && q_end && (phase == 2'd2);

endmodule
